// ==== Bender.yml ====
package:
  name: axi_lite_sram

sources:
  - axi_lite_pkg.sv
  - sram_cfg_pkg.sv
  - axi_lite_req_capture.sv
  - sram_access_engine.sv
  - axi_lite_resp_drive.sv
  - axi_lite_sram.sv
  - target: test
    files:
      - tb_axi_lite_sram.sv

// ==== axi_lite_pkg.sv ====
`default_nettype none

package axi_lite_pkg;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int STRB_W = DATA_W / 8;

    parameter logic [1:0] RESP_OKAY   = 2'b00;
    parameter logic [1:0] RESP_DECERR = 2'b11;

    // one accepted request, address already decoded
    typedef struct packed {
        logic              is_write;
        logic              in_window;
        logic [ADDR_W-1:0] word_index; // offset from base, in words
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } req_t;

    // one finished access, routed by is_write
    typedef struct packed {
        logic              is_write;
        logic [1:0]        resp;
        logic [DATA_W-1:0] rdata;
    } resp_t;

endpackage

`default_nettype wire

// ==== axi_lite_req_capture.sv ====
`default_nettype none

module axi_lite_req_capture #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic [axi_lite_pkg::ADDR_W-1:0]   araddr,
    input  wire logic                              arvalid,
    output logic                                   arready,
    input  wire logic [axi_lite_pkg::ADDR_W-1:0]   awaddr,
    input  wire logic                              awvalid,
    output logic                                   awready,
    input  wire logic [axi_lite_pkg::DATA_W-1:0]   wdata,
    input  wire logic [axi_lite_pkg::STRB_W-1:0]   wstrb,
    input  wire logic                              wvalid,
    output logic                                   wready,
    input  wire logic                              resp_done,
    output axi_lite_pkg::req_t                     req,
    output logic                                   req_valid
);

    localparam logic [axi_lite_pkg::ADDR_W-1:0] WIN_LO = sram_cfg_pkg::MEM_BASE;
    localparam logic [axi_lite_pkg::ADDR_W-1:0] WIN_HI =
        sram_cfg_pkg::MEM_BASE + axi_lite_pkg::ADDR_W'(4 * MEM_WORDS);

    logic                              busy;
    logic                              accept_rd;
    logic                              accept_wr;
    logic [axi_lite_pkg::ADDR_W-1:0]   sel_addr;
    logic [axi_lite_pkg::ADDR_W-1:0]   offset;

    assign arready = !busy;
    assign awready = !busy;
    assign wready  = !busy;

    // read wins over a write offered in the same cycle
    assign accept_rd = !busy && arvalid;
    assign accept_wr = !busy && !arvalid && awvalid && wvalid;

    assign sel_addr = accept_rd ? araddr : awaddr;
    assign offset   = sel_addr - WIN_LO;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept_rd || accept_wr;
            if (accept_rd || accept_wr) begin
                busy <= 1'b1;
            end else if (resp_done) begin
                busy <= 1'b0; // ready again next cycle
            end
        end
    end

    // stays stable while busy, engine reads it directly
    always_ff @(posedge clk) begin
        if (accept_rd || accept_wr) begin
            req.is_write   <= accept_wr;
            req.in_window  <= (sel_addr >= WIN_LO) && (sel_addr < WIN_HI);
            req.word_index <= offset >> 2;
            req.wdata      <= wdata;
            req.wstrb      <= wstrb;
        end
    end

endmodule

`default_nettype wire

// ==== axi_lite_resp_drive.sv ====
`default_nettype none

module axi_lite_resp_drive (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire axi_lite_pkg::resp_t              resp,
    input  wire logic                             resp_valid,
    output logic [axi_lite_pkg::DATA_W-1:0]       rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  wire logic                             rready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  wire logic                             bready,
    output logic                                  resp_done
);

    // handshake on either channel frees the slave
    assign resp_done = (rvalid && rready) || (bvalid && bready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata  <= sram_cfg_pkg::INST_NOP;
            rresp  <= axi_lite_pkg::RESP_OKAY;
            rvalid <= 1'b0;
            bresp  <= axi_lite_pkg::RESP_OKAY;
            bvalid <= 1'b0;
        end else begin
            if (resp_valid && !resp.is_write) begin
                rdata  <= resp.rdata;
                rresp  <= resp.resp;
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0; // rdata kept until next read
            end

            if (resp_valid && resp.is_write) begin
                bresp  <= resp.resp;
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== axi_lite_sram.f ====
axi_lite_pkg.sv
sram_cfg_pkg.sv
axi_lite_req_capture.sv
sram_access_engine.sv
axi_lite_resp_drive.sv
axi_lite_sram.sv
tb_axi_lite_sram.sv

// ==== axi_lite_sram.sv ====
`default_nettype none

module axi_lite_sram #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    // AR
    input  wire logic [axi_lite_pkg::ADDR_W-1:0]   araddr,
    input  wire logic                              arvalid,
    output logic                                   arready,
    // R
    output logic [axi_lite_pkg::DATA_W-1:0]        rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  wire logic                              rready,
    // AW
    input  wire logic [axi_lite_pkg::ADDR_W-1:0]   awaddr,
    input  wire logic                              awvalid,
    output logic                                   awready,
    // W
    input  wire logic [axi_lite_pkg::DATA_W-1:0]   wdata,
    input  wire logic [axi_lite_pkg::STRB_W-1:0]   wstrb,
    input  wire logic                              wvalid,
    output logic                                   wready,
    // B
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  wire logic                              bready
);

    axi_lite_pkg::req_t  req;
    logic                req_valid;
    axi_lite_pkg::resp_t resp;
    logic                resp_valid;
    logic                resp_done;

    axi_lite_req_capture #(
        .MEM_WORDS (MEM_WORDS)
    ) i_req_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .resp_done (resp_done),
        .req       (req),
        .req_valid (req_valid)
    );

    sram_access_engine #(
        .MEM_WORDS (MEM_WORDS)
    ) i_access_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    axi_lite_resp_drive i_resp_drive (
        .clk        (clk),
        .rst_n      (rst_n),
        .resp       (resp),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .resp_done  (resp_done)
    );

endmodule

`default_nettype wire

// ==== sram_access_engine.sv ====
`default_nettype none

module sram_access_engine #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire axi_lite_pkg::req_t  req,
    input  wire logic                req_valid,
    output axi_lite_pkg::resp_t      resp,
    output logic                     resp_valid
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [axi_lite_pkg::DATA_W-1:0] mem [MEM_WORDS];

    logic [2:0]       lfsr;
    logic [2:0]       lat;   // latency taken at req_valid
    logic [2:0]       cnt;
    logic             active;
    logic             do_access;
    logic [IDX_W-1:0] idx;

    assign idx       = req.word_index[IDX_W-1:0];
    assign do_access = active && (cnt == lat);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr       <= sram_cfg_pkg::LFSR_SEED;
            lat        <= 3'd0;
            cnt        <= 3'd0;
            active     <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= do_access;
            if (req_valid) begin
                lat    <= lfsr; // never zero
                cnt    <= 3'd1;
                active <= 1'b1;
            end else if (do_access) begin
                active <= 1'b0;
            end else if (active) begin
                cnt <= cnt + 3'd1;
            end else begin
                // steps only while idle so the wait differs per request
                lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
            end
        end
    end

    // array and response payload
    always_ff @(posedge clk) begin
        if (do_access) begin
            resp.is_write <= req.is_write;
            if (!req.in_window) begin
                resp.resp  <= axi_lite_pkg::RESP_DECERR;
                resp.rdata <= sram_cfg_pkg::INST_NOP;
            end else begin
                resp.resp  <= axi_lite_pkg::RESP_OKAY;
                resp.rdata <= mem[idx];
                if (req.is_write) begin
                    for (int b = 0; b < axi_lite_pkg::STRB_W; b++) begin
                        if (req.wstrb[b]) begin
                            mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sram_cfg_pkg.sv ====
`default_nettype none

package sram_cfg_pkg;

    // start of the memory window
    parameter logic [31:0] MEM_BASE = 32'h8000_0000;

    // addi x0, x0, 0
    parameter logic [31:0] INST_NOP = 32'h0000_0013;

    // any non-zero value works, zero would lock the lfsr
    parameter logic [2:0] LFSR_SEED = 3'b001;

endpackage

`default_nettype wire

// ==== tb_axi_lite_sram.sv ====
`default_nettype none

module tb_axi_lite_sram;

    localparam int MEM_WORDS  = 64;
    localparam int NUM_TXN    = 300;
    localparam int MAX_CYCLES = NUM_TXN * 40;

    localparam int PEND_NONE  = 0;
    localparam int PEND_READ  = 1;
    localparam int PEND_WRITE = 2;

    logic                            clk;
    logic                            rst_n;
    logic [axi_lite_pkg::ADDR_W-1:0] araddr;
    logic                            arvalid;
    logic                            arready;
    logic [axi_lite_pkg::DATA_W-1:0] rdata;
    logic [1:0]                      rresp;
    logic                            rvalid;
    logic                            rready;
    logic [axi_lite_pkg::ADDR_W-1:0] awaddr;
    logic                            awvalid;
    logic                            awready;
    logic [axi_lite_pkg::DATA_W-1:0] wdata;
    logic [axi_lite_pkg::STRB_W-1:0] wstrb;
    logic                            wvalid;
    logic                            wready;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;

    logic [31:0] model_mem [MEM_WORDS]; // reference copy of the array

    integer      seed;
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [31:0] rnd_ready;
    logic [31:0] addr;
    int          mismatch_errs;
    int          other_errs;
    int          txn_cnt;
    int          cycle_cnt;

    int          pend_kind;   // what the slave owes us
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    logic        ar_fire;
    logic        w_fire;
    logic        r_hold;
    logic        b_hold;
    logic [31:0] held_rdata;
    logic [1:0]  held_rresp;
    logic [1:0]  held_bresp;

    axi_lite_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) i_axi_lite_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] word_addr(input int idx);
        return sram_cfg_pkg::MEM_BASE + 32'(4 * idx);
    endfunction

    function automatic logic addr_in_window(input logic [31:0] a);
        return (a >= sram_cfg_pkg::MEM_BASE) &&
               (a < sram_cfg_pkg::MEM_BASE + 32'(4 * MEM_WORDS));
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        mismatch_errs++;
        $display("Mismatch %s at %0t: expected %h, got %h", name, $time, exp, act);
    endtask

    task automatic accept_read(input logic [31:0] a);
        txn_cnt++;
        pend_kind = PEND_READ;
        if (addr_in_window(a)) begin
            exp_data = model_mem[(a - sram_cfg_pkg::MEM_BASE) >> 2];
            exp_resp = axi_lite_pkg::RESP_OKAY;
        end else begin
            exp_data = sram_cfg_pkg::INST_NOP;
            exp_resp = axi_lite_pkg::RESP_DECERR;
        end
    endtask

    task automatic accept_write(input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] s);
        int idx;
        txn_cnt++;
        pend_kind = PEND_WRITE;
        if (addr_in_window(a)) begin
            idx = (a - sram_cfg_pkg::MEM_BASE) >> 2;
            for (int b = 0; b < 4; b++) begin
                if (s[b]) model_mem[idx][8*b +: 8] = d[8*b +: 8];
            end
            exp_resp = axi_lite_pkg::RESP_OKAY;
        end else begin
            exp_resp = axi_lite_pkg::RESP_DECERR; // memory untouched
        end
    endtask

    // checks the DUT outputs seen at one rising edge and drives the readies
    task automatic clock_step();
        @(posedge clk);
        ar_fire = 1'b0;
        w_fire  = 1'b0;
        if (pend_kind != PEND_NONE && (arready || awready || wready)) begin
            other_errs++;
            $display("ready output high while a request is in flight at %0t", $time);
        end
        if (r_hold) begin
            if (!rvalid) begin
                other_errs++;
                $display("rvalid dropped before rready at %0t", $time);
            end
            if (rdata !== held_rdata) report_mismatch("rdata", held_rdata, rdata);
            if (rresp !== held_rresp) report_mismatch("rresp", held_rresp, rresp);
        end
        if (b_hold) begin
            if (!bvalid) begin
                other_errs++;
                $display("bvalid dropped before bready at %0t", $time);
            end
            if (bresp !== held_bresp) report_mismatch("bresp", held_bresp, bresp);
        end
        if (rvalid && pend_kind != PEND_READ) begin
            other_errs++;
            $display("read response without a pending read at %0t", $time);
        end
        if (bvalid && pend_kind != PEND_WRITE) begin
            other_errs++;
            $display("write response without a pending write at %0t", $time);
        end
        if (rvalid && rready && pend_kind == PEND_READ) begin
            if (rdata !== exp_data) report_mismatch("rdata", exp_data, rdata);
            if (rresp !== exp_resp) report_mismatch("rresp", exp_resp, rresp);
            pend_kind = PEND_NONE;
        end
        if (bvalid && bready && pend_kind == PEND_WRITE) begin
            if (bresp !== exp_resp) report_mismatch("bresp", exp_resp, bresp);
            pend_kind = PEND_NONE;
        end
        r_hold     = rvalid && !rready;
        held_rdata = rdata;
        held_rresp = rresp;
        b_hold     = bvalid && !bready;
        held_bresp = bresp;
        // read wins when both are offered
        if (arvalid && arready) begin
            ar_fire = 1'b1;
            accept_read(araddr);
        end else if (awvalid && wvalid && awready && wready) begin
            w_fire = 1'b1;
            accept_write(awaddr, wdata, wstrb);
        end
        rnd_ready = $random(seed);
        rready <= rnd_ready[0];
        bready <= rnd_ready[1];
    endtask

    task automatic run_txn(input logic rd, input logic wr, input logic [31:0] raddr,
                           input logic [31:0] waddr, input logic [31:0] wd,
                           input logic [3:0] ws);
        logic rd_left;
        logic wr_left;
        rd_left = rd;
        wr_left = wr;
        arvalid <= rd;
        araddr  <= raddr;
        awvalid <= wr;
        wvalid  <= wr;
        awaddr  <= waddr;
        wdata   <= wd;
        wstrb   <= ws;
        while (rd_left || wr_left || pend_kind != PEND_NONE) begin
            clock_step();
            if (ar_fire) begin
                rd_left = 1'b0;
                arvalid <= 1'b0;
            end
            if (w_fire) begin
                wr_left = 1'b0;
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
            end
        end
    endtask

    task automatic end_run();
        $display("%0d mismatches, %0d other errors, %0d transactions",
                 mismatch_errs, other_errs, txn_cnt);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_errs++;
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
        end_run();
    end

    initial begin
        seed          = 32'h93e7424f;
        mismatch_errs = 0;
        other_errs    = 0;
        txn_cnt       = 0;
        pend_kind     = PEND_NONE;
        r_hold        = 1'b0;
        b_hold        = 1'b0;
        clk           = 1'b0;
        rst_n   <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        clock_step();
        if (!(arready === 1'b1 && awready === 1'b1 && wready === 1'b1)) begin
            other_errs++;
            $display("ready outputs not all high after reset");
        end
        if (rvalid !== 1'b0 || bvalid !== 1'b0) begin
            other_errs++;
            $display("a response valid is high after reset");
        end
        if (rdata !== sram_cfg_pkg::INST_NOP) begin
            report_mismatch("rdata", sram_cfg_pkg::INST_NOP, rdata);
        end

        // fill every word and read back at random
        for (int i = 0; i < MEM_WORDS; i++) begin
            rnd = $random(seed);
            run_txn(1'b0, 1'b1, '0, word_addr(i), rnd, 4'hf);
        end
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            run_txn(1'b1, 1'b0, word_addr(rnd % MEM_WORDS), '0, '0, '0);
        end

        // partial strobes
        for (int i = 0; i < 50; i++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            run_txn(1'b0, 1'b1, '0, word_addr(rnd % MEM_WORDS), rnd2, rnd[11:8]);
        end
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            run_txn(1'b1, 1'b0, word_addr(rnd % MEM_WORDS), '0, '0, '0);
        end

        // out-of-window accesses each followed by an in-window read
        for (int i = 0; i < 15; i++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            if (rnd[0]) begin
                addr = {1'b0, rnd[30:2], 2'b00}; // below base
            end else begin
                addr = word_addr(MEM_WORDS) + {12'b0, rnd[19:2], 2'b00};
            end
            if (rnd[1]) begin
                run_txn(1'b1, 1'b0, addr, '0, '0, '0);
            end else begin
                run_txn(1'b0, 1'b1, '0, addr, rnd2, 4'hf);
            end
            // word the low address bits alias to inside the array
            run_txn(1'b1, 1'b0,
                    word_addr(((addr - sram_cfg_pkg::MEM_BASE) >> 2) % MEM_WORDS),
                    '0, '0, '0);
        end

        // read and write offered together on the same word
        for (int i = 0; i < 10; i++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            addr = word_addr(rnd % MEM_WORDS);
            run_txn(1'b1, 1'b1, addr, addr, rnd2, rnd[15:12]);
            run_txn(1'b1, 1'b0, addr, '0, '0, '0);
        end

        end_run();
    end

endmodule

`default_nettype wire
